/* gmii_rx_frontend.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module gmii_rx_frontend (
  input  logic                  rx_clk,
  input  logic                  rstn_mac,
  input  logic                  rx_dv,
  input  logic [`RX_DATA_W-1:0] rxd,
  output rx_mac_pkg::rx_byte_t  rx_stream
);

  typedef enum logic [1:0] {
    S_IDLE,     // line quiet
    S_HUNT,     // preamble, waiting for sfd
    S_FRAME,    // passing bytes
    S_DISCARD   // cut frame, wait for dv low
  } fe_state_t;

  fe_state_t             state;
  logic [`RX_IDX_W-1:0]  byte_cnt;
  logic                  valid_q;
  logic                  sof_q;
  logic                  eof_q;
  logic [`RX_DATA_W-1:0] data_q;
  logic [`RX_IDX_W-1:0]  idx_q;
  logic                  is_sfd;
  logic                  frame_end;

  assign is_sfd    = (rxd == `SFD_BYTE);
  assign frame_end = !rx_dv || (byte_cnt == `TRUNC_LEN);  // dv drop or cut length

  // ========================================
  // frame state and byte index
  // ========================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      state    <= S_IDLE;
      byte_cnt <= '0;
      valid_q  <= 1'b0;
      sof_q    <= 1'b0;
      eof_q    <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      sof_q   <= 1'b0;
      eof_q   <= 1'b0;
      case (state)
        S_IDLE: begin
          if (rx_dv) begin
            byte_cnt <= '0;
            state    <= is_sfd ? S_FRAME : S_HUNT;  // sfd cycle gives no item
          end
        end
        S_HUNT: begin
          if (!rx_dv) begin
            state <= S_IDLE;   // burst without sfd
          end else if (is_sfd) begin
            state <= S_FRAME;
          end
        end
        S_FRAME: begin
          if (frame_end) begin
            eof_q <= (byte_cnt != '0);  // empty frame is dropped silently
            state <= rx_dv ? S_DISCARD : S_IDLE;
          end else begin
            valid_q  <= 1'b1;
            sof_q    <= (byte_cnt == '0);
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        S_DISCARD: begin
          if (!rx_dv) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // payload stage
  always_ff @(posedge rx_clk) begin
    data_q <= rxd;
    idx_q  <= byte_cnt;
  end

  assign rx_stream = '{valid: valid_q, sof: sof_q, eof: eof_q, data: data_q, idx: idx_q};

  // truncation keeps the index below the cut length
  a_idx_range: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    rx_stream.valid |-> (rx_stream.idx <= `TRUNC_LEN - 1));

endmodule

`default_nettype wire

/* gmii_rx_mac.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module gmii_rx_mac (
  input  logic                  rx_clk,
  input  logic                  rstn_mac,
  input  logic                  rx_dv,
  input  logic [`RX_DATA_W-1:0] rxd,
  input  logic                  data_rd,
  input  logic                  desc_rd,
  output logic [`RX_DATA_W-1:0] data_dout,
  output logic                  data_empty,
  output rx_mac_pkg::rx_desc_t  desc_dout,
  output logic                  desc_empty,
  output logic [15:0]           drop_count
);

  import rx_mac_pkg::*;

  rx_byte_t              rx_stream;
  rx_desc_t              desc_din;
  logic                  crc_done;
  logic                  crc_err;
  logic                  class_done;
  logic                  tte;
  logic                  len_err;
  logic [`RX_IDX_W-1:0]  len;
  logic [`RX_IDX_W-1:0]  data_free;
  logic                  data_wr;
  logic [`RX_DATA_W-1:0] data_din;
  logic                  desc_wr;
  logic                  desc_full;

  // ========================================
  // receive path
  // ========================================
  gmii_rx_frontend u_frontend (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .rx_dv    (rx_dv),
    .rxd      (rxd),
    .rx_stream(rx_stream)
  );

  rx_crc_check u_crc (
    .rx_clk   (rx_clk),
    .rstn_mac (rstn_mac),
    .rx_stream(rx_stream),
    .crc_done (crc_done),
    .crc_err  (crc_err)
  );

  rx_frame_classify u_classify (
    .rx_clk    (rx_clk),
    .rstn_mac  (rstn_mac),
    .rx_stream (rx_stream),
    .class_done(class_done),
    .tte       (tte),
    .len_err   (len_err),
    .len       (len)
  );

  rx_queue_writer u_writer (
    .rx_clk    (rx_clk),
    .rstn_mac  (rstn_mac),
    .rx_stream (rx_stream),
    .crc_done  (crc_done),
    .crc_err   (crc_err),
    .class_done(class_done),
    .tte       (tte),
    .len_err   (len_err),
    .len       (len),
    .data_free (data_free),
    .desc_full (desc_full),
    .data_wr   (data_wr),
    .data_din  (data_din),
    .desc_wr   (desc_wr),
    .desc_din  (desc_din),
    .drop_count(drop_count)
  );

  // ========================================
  // queues
  // ========================================
  sync_fifo #(.DEPTH(`DATA_Q_DEPTH), .WIDTH(`RX_DATA_W)) u_data_q (
    .rx_clk  (rx_clk),
    .rstn_mac(rstn_mac),
    .wr      (data_wr),
    .din     (data_din),
    .rd      (data_rd),
    .dout    (data_dout),
    .empty   (data_empty),
    .full    (),            // admission works from free
    .free    (data_free)
  );

  sync_fifo #(.DEPTH(`DESC_Q_DEPTH), .WIDTH(`DESC_W)) u_desc_q (
    .rx_clk  (rx_clk),
    .rstn_mac(rstn_mac),
    .wr      (desc_wr),
    .din     (desc_din),
    .rd      (desc_rd),
    .dout    (desc_dout),
    .empty   (desc_empty),
    .full    (desc_full),
    .free    ()
  );

endmodule

`default_nettype wire

/* rx_crc_check.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module rx_crc_check (
  input  logic                 rx_clk,
  input  logic                 rstn_mac,
  input  rx_mac_pkg::rx_byte_t rx_stream,
  output logic                 crc_done,
  output logic                 crc_err
);

  localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // 802.3, reflected

  logic [31:0] crc_q;
  logic [31:0] crc_seed;
  logic [31:0] crc_rev;

  // one byte, lsb first
  function automatic logic [31:0] crc_byte(input logic [31:0]           crc,
                                           input logic [`RX_DATA_W-1:0] d);
    logic [31:0] c;
    c = crc ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
    end
    return c;
  endfunction

  assign crc_seed = rx_stream.sof ? 32'hFFFF_FFFF : crc_q;  // preset on first byte

  always_ff @(posedge rx_clk) begin
    if (rx_stream.valid) begin
      crc_q <= crc_byte(crc_seed, rx_stream.data);  // fcs bytes go through too
    end
  end

  // residue constant is in msb-first order
  assign crc_rev = {<<{crc_q}};

  // ========================================
  // result one cycle after eof
  // ========================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      crc_done <= 1'b0;
      crc_err  <= 1'b0;
    end else begin
      crc_done <= rx_stream.eof;
      if (rx_stream.eof) begin
        crc_err <= (crc_rev != `CRC_RESIDUE);
      end
    end
  end

endmodule

`default_nettype wire

/* rx_frame_classify.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module rx_frame_classify (
  input  logic                 rx_clk,
  input  logic                 rstn_mac,
  input  rx_mac_pkg::rx_byte_t rx_stream,
  output logic                 class_done,
  output logic                 tte,
  output logic                 len_err,
  output logic [`RX_IDX_W-1:0] len
);

  logic [`RX_IDX_W-1:0] last_idx;
  logic [`RX_IDX_W-1:0] frame_len;
  logic                 tte_seen;

  assign frame_len = last_idx + 1'b1;

  // track the type byte and the last index
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      tte_seen <= 1'b0;
    end else if (rx_stream.valid) begin
      if (rx_stream.sof) begin
        tte_seen <= 1'b0;  // short frames never reach byte 13
      end else if (rx_stream.idx == `TTE_TYPE_IDX) begin
        tte_seen <= (rx_stream.data == `TTE_TYPE_BYTE);
      end
    end
  end

  always_ff @(posedge rx_clk) begin
    if (rx_stream.valid) begin
      last_idx <= rx_stream.idx;
    end
  end

  // ========================================
  // report one cycle after eof
  // ========================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      class_done <= 1'b0;
      tte        <= 1'b0;
      len_err    <= 1'b0;
      len        <= '0;
    end else begin
      class_done <= rx_stream.eof;
      if (rx_stream.eof) begin
        tte     <= tte_seen;
        len     <= frame_len;
        len_err <= (frame_len < `MIN_FRAME) || (frame_len > `MAX_FRAME);
      end
    end
  end

endmodule

`default_nettype wire

/* rx_mac_params.svh */
`ifndef RX_MAC_PARAMS_SVH
`define RX_MAC_PARAMS_SVH

// stream widths
`define RX_DATA_W     8
`define RX_IDX_W      13

// byte values on the wire
`define SFD_BYTE      8'hD5
`define TTE_TYPE_BYTE 8'h92
`define TTE_TYPE_IDX  13

// frame limits include the fcs
`define MIN_FRAME     64
`define MAX_FRAME     1518
`define TRUNC_LEN     (`MAX_FRAME + 1)

// crc register left by a good frame, msb-first order
`define CRC_RESIDUE   32'hC704_DD7B

// queue sizes
`define DATA_Q_DEPTH  4096
`define DESC_Q_DEPTH  32
`define DESC_W        16

`endif

/* rx_mac_pkg.sv */
`default_nettype none

`include "rx_mac_params.svh"

package rx_mac_pkg;

  // ========================================
  // byte stream from the front end
  // ========================================
  typedef struct packed {
    logic                  valid;  // one frame byte
    logic                  sof;    // with idx 0
    logic                  eof;    // valid low, cycle after last byte
    logic [`RX_DATA_W-1:0] data;
    logic [`RX_IDX_W-1:0]  idx;    // byte index after sfd
  } rx_byte_t;

  // ========================================
  // descriptor queue word
  // ========================================
  typedef struct packed {
    logic                 crc_err;
    logic                 len_err;
    logic                 tte;      // byte 13 matched
    logic [`RX_IDX_W-1:0] len;      // bytes incl fcs
  } rx_desc_t;

endpackage

`default_nettype wire

/* rx_queue_writer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module rx_queue_writer (
  input  logic                  rx_clk,
  input  logic                  rstn_mac,
  input  rx_mac_pkg::rx_byte_t  rx_stream,
  input  logic                  crc_done,
  input  logic                  crc_err,
  input  logic                  class_done,
  input  logic                  tte,
  input  logic                  len_err,
  input  logic [`RX_IDX_W-1:0]  len,
  input  logic [`RX_IDX_W-1:0]  data_free,
  input  logic                  desc_full,
  output logic                  data_wr,
  output logic [`RX_DATA_W-1:0] data_din,
  output logic                  desc_wr,
  output rx_mac_pkg::rx_desc_t  desc_din,
  output logic [15:0]           drop_count
);

  import rx_mac_pkg::*;

  rx_desc_t desc_next;
  logic     space_ok;
  logic     admit_now;
  logic     admitted;   // current frame goes to the queues

  // room for a full length frame plus one descriptor
  assign space_ok  = (data_free >= `TRUNC_LEN) && !desc_full;
  assign admit_now = rx_stream.sof ? space_ok : admitted;

  assign desc_next = '{crc_err: crc_err, len_err: len_err, tte: tte, len: len};

  // ========================================
  // admission and write strobes
  // ========================================
  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      admitted   <= 1'b0;
      data_wr    <= 1'b0;
      desc_wr    <= 1'b0;
      drop_count <= '0;
    end else begin
      data_wr <= rx_stream.valid && admit_now;
      desc_wr <= crc_done && class_done && admitted;
      if (rx_stream.valid && rx_stream.sof) begin
        admitted <= space_ok;
        if (!space_ok && (drop_count != '1)) begin
          drop_count <= drop_count + 1'b1;  // saturates
        end
      end else if (crc_done) begin
        admitted <= 1'b0;
      end
    end
  end

  always_ff @(posedge rx_clk) begin
    data_din <= rx_stream.data;
    desc_din <= desc_next;
  end

  // checker and classifier must finish together
  a_strobes_aligned: assert property (@(posedge rx_clk) disable iff (!rstn_mac)
    crc_done == class_done);

endmodule

`default_nettype wire

/* sync_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module sync_fifo #(
  parameter int DEPTH = 32,   // power of two, at most 4096
  parameter int WIDTH = 8
) (
  input  logic                 rx_clk,
  input  logic                 rstn_mac,
  input  logic                 wr,
  input  logic [WIDTH-1:0]     din,
  input  logic                 rd,
  output logic [WIDTH-1:0]     dout,
  output logic                 empty,
  output logic                 full,
  output logic [`RX_IDX_W-1:0] free
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr && !full;
  assign do_rd = rd && !empty;
  assign empty = (count == '0);
  assign full  = (count == (AW+1)'(DEPTH));
  assign free  = `RX_IDX_W'(DEPTH - count);

  always_ff @(posedge rx_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  assign dout = mem[rd_ptr];  // head word shows while not empty

  always_ff @(posedge rx_clk or negedge rstn_mac) begin
    if (!rstn_mac) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge rx_clk) disable iff (!rstn_mac) !(wr && full));
  a_no_underflow: assert property (@(posedge rx_clk) disable iff (!rstn_mac) !(rd && empty));

endmodule

`default_nettype wire

/* tb_rx_tasks.svh */
`ifndef TB_RX_TASKS_SVH
`define TB_RX_TASKS_SVH

// ========================================
// frame building
// ========================================

// 802.3 fcs, bit-serial, lsb of each byte first
function automatic logic [31:0] frame_fcs();
  logic [31:0] crc;
  logic        fb;
  crc = 32'hFFFF_FFFF;
  foreach (tx_frame[i]) begin
    for (int b = 0; b < 8; b++) begin
      fb  = crc[0] ^ tx_frame[i][b];
      crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
    end
  end
  return ~crc;
endfunction

// random body, type byte at index 13, fcs appended low byte first
task automatic build_frame(input int len, input logic [7:0] type_byte);
  logic [31:0] r;
  logic [31:0] fcs;
  tx_frame.delete();
  for (int i = 0; i < len - 4; i++) begin
    r = $urandom;
    tx_frame.push_back(r[7:0]);
  end
  if (len - 4 > `TTE_TYPE_IDX) tx_frame[`TTE_TYPE_IDX] = type_byte;
  fcs = frame_fcs();
  for (int k = 0; k < 4; k++) tx_frame.push_back(fcs[8*k +: 8]);
endtask

// ========================================
// gmii drive, one byte per falling edge
// ========================================
task automatic send_frame();
  for (int i = 0; i < 8; i++) begin
    @(negedge rx_clk);
    rx_dv = 1'b1;
    rxd   = (i == 7) ? `SFD_BYTE : 8'h55;  // 7 preamble + sfd
  end
  foreach (tx_frame[i]) begin
    @(negedge rx_clk);
    rxd = tx_frame[i];
  end
  @(negedge rx_clk);
  rx_dv = 1'b0;
  rxd   = 8'h00;
  repeat (12) @(negedge rx_clk);  // interframe gap
endtask

task automatic send_preamble_only(input int n);
  for (int i = 0; i < n; i++) begin
    @(negedge rx_clk);
    rx_dv = 1'b1;
    rxd   = 8'h55;
  end
  @(negedge rx_clk);
  rx_dv = 1'b0;
  rxd   = 8'h00;
endtask

// ========================================
// queue reads
// ========================================
task automatic read_desc(output rx_desc_t d, output bit got);
  int waited;
  got    = 1'b0;
  waited = 0;
  d      = '0;
  while (desc_empty && waited < 100) begin
    @(negedge rx_clk);
    waited++;
  end
  if (desc_empty) begin
    $display("%s: timeout waiting for a descriptor", test_name);
    errors++;
  end else begin
    d       = desc_dout;
    got     = 1'b1;
    desc_rd = 1'b1;
    @(negedge rx_clk);
    desc_rd = 1'b0;
  end
endtask

// pops n bytes and compares them with the expected byte queue
task automatic read_and_compare(input int n);
  int          waited;
  logic [7:0]  exp_byte;
  for (int i = 0; i < n; i++) begin
    waited = 0;
    while (data_empty && waited < 100) begin
      @(negedge rx_clk);
      waited++;
    end
    if (data_empty) begin
      $display("%s: timeout waiting for data byte %0d", test_name, i);
      errors++;
      return;
    end
    if (expect_q.size() == 0) begin
      $display("%s: data queue holds more bytes than were expected", test_name);
      errors++;
      return;
    end
    exp_byte = expect_q.pop_front();
    check_value("data byte", exp_byte, data_dout);
    data_rd = 1'b1;
    @(negedge rx_clk);
    data_rd = 1'b0;
  end
endtask

`endif

/* tb_gmii_rx_mac.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rx_mac_params.svh"

module tb_gmii_rx_mac;

  import rx_mac_pkg::*;

  logic                  rx_clk;
  logic                  rstn_mac;
  logic                  rx_dv;
  logic [`RX_DATA_W-1:0] rxd;
  logic                  data_rd;
  logic                  desc_rd;
  logic [`RX_DATA_W-1:0] data_dout;
  logic                  data_empty;
  rx_desc_t              desc_dout;
  logic                  desc_empty;
  logic [15:0]           drop_count;

  logic [7:0]  tx_frame[$];  // frame on the wire, fcs included
  logic [7:0]  expect_q[$];  // bytes the data queue should return
  string       test_name;
  int          errors;

  gmii_rx_mac i_dut (
    .rx_clk    (rx_clk),
    .rstn_mac  (rstn_mac),
    .rx_dv     (rx_dv),
    .rxd       (rxd),
    .data_rd   (data_rd),
    .desc_rd   (desc_rd),
    .data_dout (data_dout),
    .data_empty(data_empty),
    .desc_dout (desc_dout),
    .desc_empty(desc_empty),
    .drop_count(drop_count)
  );

  always #2 rx_clk = ~rx_clk;  // 4 ns

  task automatic check_value(input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // exp_crc below zero means the crc flag is not checked
  task automatic check_desc(input int exp_len, input logic exp_len_err,
                            input logic exp_tte, input int exp_crc);
    rx_desc_t d;
    bit       got;
    read_desc(d, got);
    if (got) begin
      check_value("desc len", exp_len, d.len);
      check_value("desc tte", exp_tte, d.tte);
      check_value("desc len_err", exp_len_err, d.len_err);
      if (exp_crc >= 0) check_value("desc crc_err", exp_crc, d.crc_err);
    end
  endtask

  `include "tb_rx_tasks.svh"

  // hard stop for the whole run
  initial begin
    #2_000_000;
    $display("simulation watchdog expired before the test sequence finished");
    $display("Test failures found");
    $finish;
  end

  // ========================================
  // test sequence
  // ========================================
  initial begin
    logic [15:0] drops_before;
    bit          stray;
    void'($urandom(32'h13b4_c7f7));
    rx_clk   = 1'b0;
    rstn_mac = 1'b0;
    rx_dv    = 1'b0;
    rxd      = '0;
    data_rd  = 1'b0;
    desc_rd  = 1'b0;
    errors   = 0;
    repeat (8) @(negedge rx_clk);
    rstn_mac = 1'b1;

    test_name = "reset";
    check_value("data_empty", 1, data_empty);
    check_value("desc_empty", 1, desc_empty);
    check_value("drop_count", 0, drop_count);

    test_name = "good_frame";
    build_frame(100, 8'h08);
    foreach (tx_frame[i]) expect_q.push_back(tx_frame[i]);
    send_frame();
    check_desc(100, 1'b0, 1'b0, 0);
    read_and_compare(100);

    test_name = "tte_frame";
    build_frame(100, `TTE_TYPE_BYTE);
    foreach (tx_frame[i]) expect_q.push_back(tx_frame[i]);
    send_frame();
    check_desc(100, 1'b0, 1'b1, 0);
    read_and_compare(100);

    test_name = "crc_error";
    build_frame(100, 8'h08);
    tx_frame[20] = tx_frame[20] ^ 8'h5A;  // corrupt after fcs
    foreach (tx_frame[i]) expect_q.push_back(tx_frame[i]);
    send_frame();
    check_desc(100, 1'b0, 1'b0, 1);
    read_and_compare(100);

    test_name = "short_frame";
    build_frame(60, 8'h08);
    foreach (tx_frame[i]) expect_q.push_back(tx_frame[i]);
    send_frame();
    check_desc(60, 1'b1, 1'b0, 0);
    read_and_compare(60);

    test_name = "long_frame";
    build_frame(1600, 8'h08);
    for (int i = 0; i < `TRUNC_LEN; i++) expect_q.push_back(tx_frame[i]);
    send_frame();
    check_desc(`TRUNC_LEN, 1'b1, 1'b0, -1);  // cut frame, fcs lost
    read_and_compare(`TRUNC_LEN);
    check_value("data_empty after cut", 1, data_empty);

    // 33 frames into a 32 entry descriptor queue
    test_name = "backpressure";
    for (int f = 0; f < 33; f++) begin
      build_frame(64, 8'h08);
      if (f < 32) foreach (tx_frame[i]) expect_q.push_back(tx_frame[i]);
      send_frame();
    end
    check_value("drop_count", 1, drop_count);
    for (int f = 0; f < 32; f++) begin
      check_desc(64, 1'b0, 1'b0, 0);
      read_and_compare(64);
    end
    check_value("desc_empty after drain", 1, desc_empty);
    check_value("data_empty after drain", 1, data_empty);

    test_name = "no_sfd";
    drops_before = drop_count;
    stray        = 1'b0;
    send_preamble_only(7);
    for (int c = 0; c < 40; c++) begin
      @(negedge rx_clk);
      if (!data_empty || !desc_empty) stray = 1'b1;
    end
    check_value("queue written", 0, stray);
    check_value("drop_count", drops_before, drop_count);

    $display("test sequence done, error count: %0d", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
rx_mac_pkg.sv
gmii_rx_frontend.sv
rx_crc_check.sv
rx_frame_classify.sv
rx_queue_writer.sv
sync_fifo.sv
gmii_rx_mac.sv
tb_gmii_rx_mac.sv
